// File: filelist.f
logic/pod_pkg.sv
logic/north_edge.sv
logic/tile_row.sv
logic/south_edge.sv
logic/pod_column.sv
testbench/pod_column_tb.sv

// File: run.sh
#!/bin/sh
# build the pod column testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module pod_column_tb \
  --Mdir obj_dir -o pod_column_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pod_column_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

exit 0

// File: testbench/pod_column_tb.sv
// pod column testbench with a host model, a response sink and a reference memory model
`default_nettype none

module pod_column_tb
  import pod_pkg::*;
();

  localparam int GLOBAL_Y       = 5;
  localparam int TIMEOUT_CYCLES = 4000;

  logic                clk_i = 1'b0;
  logic                rst_i;
  logic                req_i;
  link_pkt_t           pkt_i;
  logic                ack_i;
  logic [Y_CORD_W-1:0] global_y_i;
  logic                ack_o;
  logic                req_o;
  link_pkt_t           pkt_o;

  integer              seed = 15;
  logic [DATA_W-1:0]   ref_mem [NUM_ROWS*DMEM_WORDS];
  link_pkt_t           exp_q [$];
  int                  n_checks;
  int                  n_errors;
  int                  n_acked;
  int                  cycle_cnt;

  always #50 clk_i = ~clk_i;

  pod_column u_pod_column (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .pkt_i      (pkt_i),
    .ack_i      (ack_i),
    .global_y_i (global_y_i),
    .ack_o      (ack_o),
    .req_o      (req_o),
    .pkt_o      (pkt_o)
  );

  function automatic link_pkt_t make_pkt(pod_op_e op, int y, int addr,
                                         logic [DATA_W-1:0] data);
    link_pkt_t p;
    p.op     = op;
    p.y_cord = Y_CORD_W'(y);
    p.addr   = ADDR_W'(addr);
    p.data   = data;
    return p;
  endfunction

  // predicted response that also applies stores to the memory model
  function automatic link_pkt_t predict(link_pkt_t p);
    link_pkt_t r;
    int        row;
    int        idx;
    r   = p;
    row = int'(p.y_cord) - GLOBAL_Y - 1;
    if ((p.op == op_load || p.op == op_store) && row >= 0 && row < NUM_ROWS) begin
      idx = row * DMEM_WORDS + int'(p.addr);
      if (p.op == op_store) begin
        ref_mem[idx] = p.data;
      end
      r.op   = op_resp;
      r.data = ref_mem[idx];
    end
    return r;
  endfunction

  // four-phase request from the host side
  task automatic send_req(input link_pkt_t p);
    exp_q.push_back(predict(p));
    @(negedge clk_i);
    req_i = 1'b1;
    pkt_i = p;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    req_i = 1'b0;
    while (ack_o) @(negedge clk_i);
  endtask

  // sink checks the response then closes the handshake
  task automatic recv_resp();
    link_pkt_t exp_pkt;
    while (!req_o) @(negedge clk_i);
    n_checks++;
    if (exp_q.size() == 0) begin
      n_errors++;
      $display("error at time %0t: response arrived with no request outstanding", $time);
    end else begin
      exp_pkt = exp_q.pop_front();
      if (pkt_o !== exp_pkt) begin
        n_errors++;
        $display("error at time %0t: pkt_o expected %h got %h", $time, exp_pkt, pkt_o);
      end
    end
    ack_i = 1'b1;
    @(negedge clk_i);
    while (req_o) @(negedge clk_i);
    ack_i = 1'b0;
  endtask

  task automatic send_and_check(input link_pkt_t p);
    send_req(p);
    recv_resp();
  endtask

  task automatic loads_after_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int a = 0; a < DMEM_WORDS; a++) begin
        send_and_check(make_pkt(op_load, GLOBAL_Y + 1 + r, a, '0));
      end
    end
  endtask

  task automatic store_then_load();
    logic [DATA_W-1:0] d;
    for (int r = 0; r < NUM_ROWS; r++) begin
      d = DATA_W'($random(seed));
      send_and_check(make_pkt(op_store, GLOBAL_Y + 1 + r, r, d));
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_and_check(make_pkt(op_load, GLOBAL_Y + 1 + r, r, '0));
    end
  endtask

  task automatic row_independence();
    logic [DATA_W-1:0] d;
    for (int r = 0; r < NUM_ROWS; r++) begin
      d = DATA_W'($random(seed));
      send_and_check(make_pkt(op_store, GLOBAL_Y + 1 + r, 2, d));
    end
    // every word of every row
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int a = 0; a < DMEM_WORDS; a++) begin
        send_and_check(make_pkt(op_load, GLOBAL_Y + 1 + r, a, '0));
      end
    end
  endtask

  // y 5 is the north edge itself and y 9 lies past the last row
  task automatic unmatched_pass_through();
    send_and_check(make_pkt(op_load, GLOBAL_Y, 1, DATA_W'($random(seed))));
    send_and_check(make_pkt(op_store, GLOBAL_Y, 2, DATA_W'($random(seed))));
    send_and_check(make_pkt(op_load, GLOBAL_Y + 1 + NUM_ROWS, 3, DATA_W'($random(seed))));
    send_and_check(make_pkt(op_store, GLOBAL_Y + 1 + NUM_ROWS, 0, DATA_W'($random(seed))));
  endtask

  task automatic back_pressure();
    link_pkt_t reqs [6];
    for (int r = 0; r < NUM_ROWS; r++) begin
      reqs[r]            = make_pkt(op_store, GLOBAL_Y + 1 + r, 3, DATA_W'($random(seed)));
      reqs[r + NUM_ROWS] = make_pkt(op_load, GLOBAL_Y + 1 + r, 3, '0);
    end
    n_acked = 0;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          send_req(reqs[i]);
          n_acked++;
        end
      end
      begin
        // the sixth request waits once all five stages hold a packet
        while (n_acked < NUM_ROWS + 2) @(negedge clk_i);
        repeat (20) begin
          @(negedge clk_i);
          n_checks++;
          if (ack_o !== 1'b0) begin
            n_errors++;
            $display("error at time %0t: ack_o expected 0 got %b", $time, ack_o);
          end
        end
        n_checks++;
        if (n_acked != NUM_ROWS + 2) begin
          n_errors++;
          $display("error at time %0t: acked requests expected %0d got %0d", $time,
                   NUM_ROWS + 2, n_acked);
        end
        repeat (6) recv_resp();
      end
    join
  endtask

  initial begin
    rst_i      = 1'b1;
    req_i      = 1'b0;
    pkt_i      = '0;
    ack_i      = 1'b0;
    global_y_i = Y_CORD_W'(GLOBAL_Y);
    n_checks   = 0;
    n_errors   = 0;
    n_acked    = 0;
    for (int i = 0; i < NUM_ROWS * DMEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    // reset still travels down the chain
    repeat (8) @(negedge clk_i);

    loads_after_reset();
    store_then_load();
    row_independence();
    unmatched_pass_through();
    back_pressure();

    n_checks++;
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("error at time %0t: %0d responses never arrived", $time, exp_q.size());
    end
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/pod_column.sv
// pod column top, north edge then the tile rows then the south edge
`default_nettype none

module pod_column
  import pod_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  input  link_pkt_t           pkt_i,
  input  logic                ack_i,
  input  logic [Y_CORD_W-1:0] global_y_i,
  output logic                ack_o,
  output logic                req_o,
  output link_pkt_t           pkt_o
);

  // index 0 is the north edge output, index k+1 the output of row k
  link_pkt_t [NUM_ROWS:0]               pkt_chain;
  logic      [NUM_ROWS:0]               valid_chain;
  logic      [NUM_ROWS:0]               ready_chain;
  logic      [NUM_ROWS:0]               rst_chain;
  logic      [NUM_ROWS:0][Y_CORD_W-1:0] y_chain;

  north_edge u_north (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .pkt_i      (pkt_i),
    .ack_o      (ack_o),
    .global_y_i (global_y_i),
    .pkt_o      (pkt_chain[0]),
    .valid_o    (valid_chain[0]),
    .ready_i    (ready_chain[0]),
    .rst_o      (rst_chain[0]),
    .y_o        (y_chain[0])
  );

  for (genvar k = 0; k < NUM_ROWS; k++) begin : g_row
    tile_row u_row (
      .clk_i   (clk_i),
      .rst_i   (rst_chain[k]),
      .y_i     (y_chain[k]),
      .pkt_i   (pkt_chain[k]),
      .valid_i (valid_chain[k]),
      .ready_o (ready_chain[k]),
      .pkt_o   (pkt_chain[k+1]),
      .valid_o (valid_chain[k+1]),
      .ready_i (ready_chain[k+1]),
      .rst_o   (rst_chain[k+1]),
      .y_o     (y_chain[k+1])
    );
  end

  south_edge u_south (
    .clk_i   (clk_i),
    .rst_i   (rst_chain[NUM_ROWS]),
    .pkt_i   (pkt_chain[NUM_ROWS]),
    .valid_i (valid_chain[NUM_ROWS]),
    .ready_o (ready_chain[NUM_ROWS]),
    .req_o   (req_o),
    .pkt_o   (pkt_o),
    .ack_i   (ack_i)
  );

endmodule

`default_nettype wire

// File: logic/south_edge.sv
// south edge stage, holds one packet and sends it out over a four-phase port
`default_nettype none

module south_edge
  import pod_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,

  // from the last tile row
  input  link_pkt_t pkt_i,
  input  logic      valid_i,
  output logic      ready_o,

  // sink side, four-phase
  output logic      req_o,
  output link_pkt_t pkt_o,
  input  logic      ack_i
);

  logic      buf_v_q;
  link_pkt_t buf_pkt_q;
  logic      req_q;
  logic      accept;
  logic      done;

  // a waiting sink keeps the buffer full and stalls the rows
  assign ready_o = ~buf_v_q;
  assign accept  = valid_i & ~buf_v_q;

  // sink has seen the packet
  assign done = req_q & ack_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_v_q <= 1'b0;
    end else if (accept) begin
      buf_v_q <= 1'b1;
    end else if (done) begin
      buf_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      buf_pkt_q <= pkt_i;
    end
  end

  // req waits for ack low from the previous transfer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
    end else if (done) begin
      req_q <= 1'b0;
    end else if (buf_v_q && !ack_i) begin
      req_q <= 1'b1;
    end
  end

  assign req_o = req_q;
  assign pkt_o = buf_pkt_q;

endmodule

`default_nettype wire

// File: logic/tile_row.sv
// compute tile row, executes loads and stores addressed to its y and forwards the rest
`default_nettype none

module tile_row
  import pod_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,

  // coordinate handed down from the stage above
  input  logic [Y_CORD_W-1:0] y_i,

  // from the stage above
  input  link_pkt_t           pkt_i,
  input  logic                valid_i,
  output logic                ready_o,

  // towards the stage below
  output link_pkt_t           pkt_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic                rst_o,
  output logic [Y_CORD_W-1:0] y_o
);

  logic [DATA_W-1:0]   dmem [DMEM_WORDS];
  logic [Y_CORD_W-1:0] my_y_q;
  logic                rst_q;
  logic                out_v_q;
  link_pkt_t           out_pkt_q;
  logic                accept;
  logic                is_mem_op;
  logic                hit;
  link_pkt_t           resp_pkt;

  // own coordinate, the row below sits one further south
  always_ff @(posedge clk_i) begin
    my_y_q <= y_i;
    rst_q  <= rst_i;
  end

  assign y_o   = my_y_q + Y_CORD_W'(1);
  assign rst_o = rst_q;

  // output register can take a packet when empty or draining this cycle
  assign ready_o = ~out_v_q | ready_i;
  assign accept  = valid_i & ready_o;

  assign is_mem_op = (pkt_i.op == op_load) || (pkt_i.op == op_store);
  assign hit       = is_mem_op && (pkt_i.y_cord == my_y_q);

  // response keeps y and addr of the request
  always_comb begin
    resp_pkt        = pkt_i;
    resp_pkt.op     = op_resp;
    if (pkt_i.op == op_load) begin
      resp_pkt.data = dmem[pkt_i.addr];
    end else begin
      resp_pkt.data = pkt_i.data;
    end
  end

  // data memory, written only on the accepting edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (accept && hit && (pkt_i.op == op_store)) begin
      dmem[pkt_i.addr] <= pkt_i.data;
    end
  end

  // pipeline register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_v_q <= 1'b0;
    end else if (ready_o) begin
      out_v_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_pkt_q <= hit ? resp_pkt : pkt_i;
    end
  end

  assign pkt_o   = out_pkt_q;
  assign valid_o = out_v_q;

endmodule

`default_nettype wire

// File: logic/north_edge.sv
// north edge stage, four-phase request receiver that starts the reset and y chains
`default_nettype none

module north_edge
  import pod_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,

  // host side, four-phase
  input  logic                req_i,
  input  link_pkt_t           pkt_i,
  output logic                ack_o,

  // y of this edge, constant in operation
  input  logic [Y_CORD_W-1:0] global_y_i,

  // towards the first tile row
  output link_pkt_t           pkt_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic                rst_o,
  output logic [Y_CORD_W-1:0] y_o
);

  logic                ack_q;
  logic                buf_v_q;
  link_pkt_t           buf_pkt_q;
  logic                capture;
  logic                rst_q;
  logic [Y_CORD_W-1:0] y_q;

  // take a request only with a free buffer and the previous handshake closed
  assign capture = req_i & ~ack_q & ~buf_v_q;

  // ack drops as soon as the host has let go of req
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else if (!req_i) begin
      ack_q <= 1'b0;
    end else if (capture) begin
      ack_q <= 1'b1;
    end
  end

  // one-packet buffer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_v_q <= 1'b0;
    end else if (capture) begin
      buf_v_q <= 1'b1;
    end else if (ready_i) begin
      buf_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      buf_pkt_q <= pkt_i;
    end
  end

  // head of the reset and coordinate chains
  always_ff @(posedge clk_i) begin
    rst_q <= rst_i;
    y_q   <= global_y_i + Y_CORD_W'(1);
  end

  assign ack_o   = ack_q;
  assign pkt_o   = buf_pkt_q;
  assign valid_o = buf_v_q;
  assign rst_o   = rst_q;
  assign y_o     = y_q;

endmodule

`default_nettype wire

// File: logic/pod_pkg.sv
// pod column package with column sizes, packet opcodes and the link packet layout
`default_nettype none

package pod_pkg;

  // column geometry
  localparam int NUM_ROWS   = 3;
  localparam int DMEM_WORDS = 4;

  // word address covers the whole data memory of a row
  localparam int ADDR_W = $clog2(DMEM_WORDS);

  // payload and coordinate widths
  localparam int DATA_W   = 16;
  localparam int Y_CORD_W = 4;

  // packet opcode
  // loads and stores travel south until a row claims them,
  // a claimed packet comes back out as a response
  typedef enum logic [1:0] {
    op_load  = 2'b00,
    op_store = 2'b01,
    op_resp  = 2'b10
  } pod_op_e;

  // link packet, 24 bits
  // msb first: op, y_cord, addr, data
  typedef struct packed {
    pod_op_e             op;
    logic [Y_CORD_W-1:0] y_cord;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } link_pkt_t;

endpackage

`default_nettype wire
